/* glb.f */
glbPkg.sv
glbBankMapDecoder.sv
glbWritePort.sv
glbBank.sv
glbReadPorts.sv
glbTop.sv
glbTb.sv

/* glbBank.sv */
// One SRAM bank of the global buffer
// Takes the broadcast write request and its own read request; the read
// word appears one cycle after the request and holds until the next read
`timescale 1ns/1ps
`default_nettype none

module glbBank import glbPkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire bankIdx_t   bankId,
    input  wire bankWrReq_t wrReq,
    input  wire bankRdReq_t rdReq,
    output word_t           rdData
);

    word_t mem [BankWords];
    logic  wrHit;

    // ==================================================================
    // Write side
    // ==================================================================

    // Only the bank named in the broadcast takes the word
    assign wrHit = wrReq.en && (wrReq.bank == bankId);

    always_ff @(posedge clk) begin
        if (wrHit) begin
            mem[wrReq.row] <= wrReq.data;
        end
    end

    // ==================================================================
    // Read side
    // ==================================================================

    // Registered output, held while no read is requested
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdData <= '0;
        end else if (rdReq.en) begin
            rdData <= mem[rdReq.row];
        end
    end

    // Same row read and written in one cycle returns the old word.
    // The read-after-write guard upstream keeps that from happening
    assert property (@(posedge clk) disable iff (!rst_n)
        !(wrHit && rdReq.en && (wrReq.row == rdReq.row)));

endmodule

`default_nettype wire

/* glbBankMapDecoder.sv */
// Configuration decoder of the global buffer
// Loads the bank-to-port map on the configuration strobe and derives, per
// read port, the number of owned banks and the rank-to-bank table
`timescale 1ns/1ps
`default_nettype none

module glbBankMapDecoder import glbPkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           cfgVld,
    input  wire bankMap_t cfgBankMap,
    output bankMap_t      bankOwner,
    output count_t        portBankCount [NumRdPort],
    output bankIdx_t      rankBank [NumRdPort][NumBank]
);

    // ==================================================================
    // Map register
    // ==================================================================

    // All zeros after reset, so port 0 owns every bank
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bankOwner <= '0;
        end else if (cfgVld) begin
            bankOwner <= cfgBankMap;
        end
    end

    // ==================================================================
    // Relative index decode
    // ==================================================================

    // Banks are scanned in index order, so the running count of a port is
    // the rank of the next bank it owns
    always_comb begin
        portIdx_t owner;
        for (int p = 0; p < NumRdPort; p++) begin
            portBankCount[p] = '0;
            for (int k = 0; k < NumBank; k++) begin
                rankBank[p][k] = '0;
            end
        end
        for (int b = 0; b < NumBank; b++) begin
            owner = bankOwner[b];
            rankBank[owner][portBankCount[owner][BankIdxWidth-1:0]] = bankIdx_t'(b);
            portBankCount[owner] = portBankCount[owner] + 1'b1;
        end
    end

    // Each used rank must land on a bank of the same port
    for (genvar p = 0; p < NumRdPort; p++) begin : genRankChk
        for (genvar k = 0; k < NumBank; k++) begin : genRank
            assert property (@(posedge clk) disable iff (!rst_n)
                (count_t'(k) < portBankCount[p])
                |-> (bankOwner[rankBank[p][k]] == portIdx_t'(p)));
        end
    end

endmodule

`default_nettype wire

/* glbPkg.sv */
// Sizes, index types and bank request structs shared by the global buffer
// Every module of the buffer pulls these in by a wildcard import
`default_nettype none

package glbPkg;

    // ==================================================================
    // Sizes
    // ==================================================================
    localparam int NumBank      = 4;
    localparam int BankWords    = 16;
    localparam int WordWidth    = 32;
    localparam int NumRdPort    = 2;
    localparam int TotalWords   = NumBank * BankWords;

    // Derived index widths
    localparam int BankIdxWidth = $clog2(NumBank);
    localparam int RowWidth     = $clog2(BankWords);
    localparam int AddrWidth    = BankIdxWidth + RowWidth;
    // One extra bit so a count can reach TotalWords
    localparam int CountWidth   = AddrWidth + 1;
    localparam int PortIdxWidth = $clog2(NumRdPort);

    // ==================================================================
    // Scalar types
    // ==================================================================
    typedef logic [WordWidth-1:0]    word_t;
    typedef logic [BankIdxWidth-1:0] bankIdx_t;
    typedef logic [RowWidth-1:0]     rowIdx_t;
    typedef logic [AddrWidth-1:0]    addr_t;
    typedef logic [CountWidth-1:0]   count_t;
    typedef logic [PortIdxWidth-1:0] portIdx_t;

    // Owning read port of each bank, indexed by bank
    typedef portIdx_t [NumBank-1:0] bankMap_t;

    // ==================================================================
    // Bank requests
    // ==================================================================

    // Write request, broadcast to all banks
    typedef struct packed {
        logic     en;
        bankIdx_t bank;
        rowIdx_t  row;
        word_t    data;
    } bankWrReq_t;

    // Read request, one per bank
    typedef struct packed {
        logic    en;
        rowIdx_t row;
    } bankRdReq_t;

endpackage

`default_nettype wire

/* glbReadPorts.sv */
// Read ports of the global buffer
// Each port walks its owned banks in rank order, holds back reads of words
// not yet written, and returns one word per request a cycle later
`timescale 1ns/1ps
`default_nettype none

module glbReadPorts import glbPkg::*; (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 cfgVld,
    input  wire bankMap_t       bankOwner,
    input  wire count_t         portBankCount [NumRdPort],
    input  wire bankIdx_t       rankBank [NumRdPort][NumBank],
    input  wire count_t         wrCount,
    input  wire [NumRdPort-1:0] rdRdy,
    input  wire word_t          bankRdData [NumBank],
    output bankRdReq_t          bankRdReq [NumBank],
    output logic [NumRdPort-1:0] rdVld,
    output word_t               rdDat [NumRdPort],
    output logic [NumRdPort-1:0] rdDone
);

    count_t   rdCnt     [NumRdPort];
    count_t   portTotal [NumRdPort];
    bankIdx_t tgtBank   [NumRdPort];
    rowIdx_t  tgtRow    [NumRdPort];
    addr_t    tgtAddr   [NumRdPort];
    bankIdx_t lastBank  [NumRdPort];

    logic [NumRdPort-1:0] slotFree;
    logic [NumRdPort-1:0] wordsLeft;
    logic [NumRdPort-1:0] rawOk;
    logic [NumRdPort-1:0] issue;

    // Which ports hit each bank this cycle
    logic [NumRdPort-1:0] bankHit [NumBank];

    // ==================================================================
    // Issue decision
    // ==================================================================
    always_comb begin
        for (int p = 0; p < NumRdPort; p++) begin
            portTotal[p] = portBankCount[p] << RowWidth;
            // Count splits into rank and row
            tgtBank[p]   = rankBank[p][rdCnt[p][AddrWidth-1:RowWidth]];
            tgtRow[p]    = rdCnt[p][RowWidth-1:0];
            tgtAddr[p]   = {tgtBank[p], tgtRow[p]};

            slotFree[p]  = !rdVld[p] || rdRdy[p];
            wordsLeft[p] = rdCnt[p] < portTotal[p];
            // Read-after-write guard against the registered write count
            rawOk[p]     = count_t'(tgtAddr[p]) < wrCount;
            // Nothing is issued in the reconfiguration cycle
            issue[p]     = !cfgVld && slotFree[p] && wordsLeft[p] && rawOk[p];
        end
    end

    // ==================================================================
    // Bank read requests
    // ==================================================================
    always_comb begin
        for (int b = 0; b < NumBank; b++) begin
            bankRdReq[b] = '0;
            bankHit[b]   = '0;
        end
        for (int p = 0; p < NumRdPort; p++) begin
            if (issue[p]) begin
                bankRdReq[tgtBank[p]].en  = 1'b1;
                bankRdReq[tgtBank[p]].row = tgtRow[p];
                bankHit[tgtBank[p]][p]    = 1'b1;
            end
        end
    end

    // ==================================================================
    // Counters and output valid
    // ==================================================================

    // Reconfiguration abandons any word still in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdVld <= '0;
            for (int p = 0; p < NumRdPort; p++) begin
                rdCnt[p]    <= '0;
                lastBank[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NumRdPort; p++) begin
                if (cfgVld) begin
                    rdCnt[p] <= '0;
                    rdVld[p] <= 1'b0;
                end else begin
                    if (issue[p]) begin
                        rdCnt[p]    <= rdCnt[p] + 1'b1;
                        lastBank[p] <= tgtBank[p];
                    end
                    if (slotFree[p]) begin
                        rdVld[p] <= issue[p];
                    end
                end
            end
        end
    end

    // Bank output holds while stalled, so the routed word does too
    always_comb begin
        for (int p = 0; p < NumRdPort; p++) begin
            rdDat[p]  = bankRdData[lastBank[p]];
            rdDone[p] = (rdCnt[p] == portTotal[p]) && !rdVld[p];
        end
    end

    // A bank is read by at most one port, and only by its owner
    for (genvar b = 0; b < NumBank; b++) begin : genBankChk
        assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(bankHit[b]));
        assert property (@(posedge clk) disable iff (!rst_n)
            (bankHit[b] != '0) |-> bankHit[b][bankOwner[b]]);
    end

endmodule

`default_nettype wire

/* glbTb.sv */
// Self-checking testbench for the banked global buffer
// Drives configuration, write and read streams with seeded random stimulus
// and checks every delivered word against a model of the memory and the map
`timescale 1ns/1ps
`default_nettype none

module glbTb import glbPkg::*; ;

    localparam int TimeoutCycles = 3000;

    logic                 clk;
    logic                 rst_n;
    logic                 cfgVld;
    bankMap_t             cfgBankMap;
    logic                 wrVld;
    word_t                wrDat;
    logic                 wrRdy;
    logic                 wrFull;
    logic [NumRdPort-1:0] rdVld;
    logic [NumRdPort-1:0] rdRdy;
    word_t                rdDat [NumRdPort];
    logic [NumRdPort-1:0] rdDone;

    // Model state
    word_t    modelMem [TotalWords];
    int       expAddr [NumRdPort][TotalWords];
    int       expLen [NumRdPort];
    int       expHead [NumRdPort];
    int       wrAccepted;
    logic     heldVld [NumRdPort];
    word_t    heldDat [NumRdPort];
    logic     noBankPort0;
    int       errorCount;
    int       testsFailed;
    int       testStartErrors;
    int       cycleCount;

    glbTop glbTop_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfgVld     (cfgVld),
        .cfgBankMap (cfgBankMap),
        .wrVld      (wrVld),
        .wrDat      (wrDat),
        .wrRdy      (wrRdy),
        .wrFull     (wrFull),
        .rdVld      (rdVld),
        .rdRdy      (rdRdy),
        .rdDat      (rdDat),
        .rdDone     (rdDone)
    );

    always #2 clk = ~clk;

    // ==================================================================
    // Helpers
    // ==================================================================
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // Owned banks in increasing index, rows 0 to 15 within each bank
    task automatic buildQueues(input bankMap_t map);
        for (int p = 0; p < NumRdPort; p++) begin
            expLen[p]  = 0;
            expHead[p] = 0;
            for (int b = 0; b < NumBank; b++) begin
                if (int'(map[b]) == p) begin
                    for (int r = 0; r < BankWords; r++) begin
                        expAddr[p][expLen[p]] = b * BankWords + r;
                        expLen[p]++;
                    end
                end
            end
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    // Read ready is dropped so no word is taken at the configuration edge
    task automatic configure(input bankMap_t map);
        cfgVld     = 1'b1;
        cfgBankMap = map;
        wrVld      = 1'b0;
        rdRdy      = '0;
        stepCycle();
        cfgVld     = 1'b0;
    endtask

    task automatic waitBothDone();
        while (rdDone !== 2'b11) begin
            stepCycle();
        end
    endtask

    task automatic checkAllDelivered();
        for (int p = 0; p < NumRdPort; p++) begin
            checkValue($sformatf("words delivered by port %0d", p), expHead[p], expLen[p]);
        end
    endtask

    task automatic finishTest(input int num, input string name);
        if (errorCount == testStartErrors) begin
            $display("Test %0d (%s): ok", num, name);
        end else begin
            $display("Test %0d (%s): %0d errors", num, name, errorCount - testStartErrors);
            testsFailed++;
        end
        testStartErrors = errorCount;
    endtask

    // ==================================================================
    // Monitor, sampled mid-cycle where all signals are settled
    // ==================================================================
    always @(negedge clk) begin
        int addr;
        if (rst_n) begin
            // Flow control follows the model's own write count
            checkValue("wrRdy", wrRdy, wrAccepted < TotalWords);
            checkValue("wrFull", wrFull, wrAccepted == TotalWords);
            for (int p = 0; p < NumRdPort; p++) begin
                // Done exactly when every queued word has been taken
                checkValue($sformatf("rdDone[%0d]", p), rdDone[p], expHead[p] == expLen[p]);
                if (heldVld[p]) begin
                    checkValue($sformatf("rdVld[%0d] while stalled", p), rdVld[p], 1'b1);
                    checkValue($sformatf("rdDat[%0d] while stalled", p), rdDat[p], heldDat[p]);
                end
                if (p == 0 && noBankPort0 && rdVld[0]) begin
                    $display("Error at %0t ns: port 0 owns no bank but raised rdVld", $time);
                    errorCount++;
                end
                if (rdVld[p] && rdRdy[p]) begin
                    if (expHead[p] >= expLen[p]) begin
                        $display("Error at %0t ns: port %0d delivered more words than expected",
                                 $time, p);
                        errorCount++;
                    end else begin
                        addr = expAddr[p][expHead[p]];
                        expHead[p]++;
                        if (addr >= wrAccepted) begin
                            $display("Error at %0t ns: port %0d delivered unwritten address %0d",
                                     $time, p, addr);
                            errorCount++;
                        end
                        checkValue($sformatf("rdDat[%0d]", p), rdDat[p], modelMem[addr]);
                    end
                end
                heldVld[p] = rdVld[p] && !rdRdy[p];
                heldDat[p] = rdDat[p];
            end
            if (wrVld && wrAccepted < TotalWords) begin
                modelMem[wrAccepted] = wrDat;
                wrAccepted++;
            end
            // Data in the banks stays, only the streams restart
            if (cfgVld) begin
                buildQueues(cfgBankMap);
                wrAccepted = 0;
                for (int p = 0; p < NumRdPort; p++) begin
                    heldVld[p] = 1'b0;
                end
            end
        end
    end

    // Cycle counter that ends a hung run
    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        $display("FAIL: see errors above");
        $finish;
    end

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        int seedInit;
        int slowCnt;
        seedInit        = $urandom(32'h540);
        clk             = 1'b0;
        rst_n           = 1'b0;
        cfgVld          = 1'b0;
        cfgBankMap      = '0;
        wrVld           = 1'b0;
        wrDat           = '0;
        rdRdy           = '0;
        wrAccepted      = 0;
        noBankPort0     = 1'b0;
        errorCount      = 0;
        testsFailed     = 0;
        testStartErrors = 0;
        for (int p = 0; p < NumRdPort; p++) begin
            heldVld[p] = 1'b0;
            heldDat[p] = '0;
        end
        buildQueues('0);
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Test 1: state after reset, no reads before any write
        checkValue("rdVld", rdVld, 2'b00);
        checkValue("wrRdy", wrRdy, 1'b1);
        checkValue("wrFull", wrFull, 1'b0);
        checkValue("rdDone", rdDone, 2'b10);
        rdRdy = 2'b01;
        repeat (10) begin
            stepCycle();
            checkValue("rdVld[0]", rdVld[0], 1'b0);
        end
        finishTest(1, "after reset");

        // Test 2: default map, port 0 streams the whole buffer
        while (wrAccepted < TotalWords) begin
            wrVld = 1'b1;
            wrDat = $urandom;
            stepCycle();
        end
        wrVld = 1'b0;
        waitBothDone();
        checkAllDelivered();
        finishTest(2, "default map");

        // Test 3: random map, write gaps and random back-pressure
        configure(bankMap_t'($urandom));
        while (!(wrAccepted == TotalWords && rdDone == 2'b11)) begin
            wrVld = (wrAccepted < TotalWords) && ($urandom % 3 != 0);
            wrDat = $urandom;
            rdRdy = $urandom;
            stepCycle();
        end
        wrVld = 1'b0;
        checkAllDelivered();
        finishTest(3, "random map with back-pressure");

        // Test 4: slow writes, reads must trail the write count
        configure(bankMap_t'($urandom));
        rdRdy   = 2'b11;
        slowCnt = 0;
        while (!(wrAccepted == TotalWords && rdDone == 2'b11)) begin
            wrVld = (wrAccepted < TotalWords) && (slowCnt % 4 == 0);
            wrDat = $urandom;
            slowCnt++;
            stepCycle();
        end
        wrVld = 1'b0;
        checkAllDelivered();
        finishTest(4, "read-after-write guard");

        // Test 5: port 0 owns nothing
        configure(4'b1111);
        checkValue("rdDone[0]", rdDone[0], 1'b1);
        noBankPort0 = 1'b1;
        rdRdy       = 2'b11;
        while (wrAccepted < TotalWords) begin
            wrVld = 1'b1;
            wrDat = $urandom;
            stepCycle();
        end
        wrVld = 1'b0;
        waitBothDone();
        checkAllDelivered();
        noBankPort0 = 1'b0;
        finishTest(5, "port with no banks");

        // Test 6: writes past full are dropped
        configure(bankMap_t'($urandom));
        while (wrAccepted < TotalWords) begin
            wrVld = 1'b1;
            wrDat = $urandom;
            stepCycle();
        end
        wrVld = 1'b0;
        stepCycle();
        checkValue("wrFull", wrFull, 1'b1);
        checkValue("wrRdy", wrRdy, 1'b0);
        repeat (8) begin
            wrVld = ~wrVld;
            wrDat = $urandom;
            stepCycle();
        end
        wrVld = 1'b0;
        rdRdy = 2'b11;
        waitBothDone();
        checkAllDelivered();
        configure(bankMap_t'($urandom));
        checkValue("wrFull", wrFull, 1'b0);
        checkValue("wrRdy", wrRdy, 1'b1);
        finishTest(6, "full buffer");

        $display("Tests run: 6, tests failed: %0d, errors: %0d", testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* glbTop.sv */
// Top level of the banked global buffer
// One linear write stream fills four banks; two read ports stream back the
// banks assigned to them by the configuration map
`timescale 1ns/1ps
`default_nettype none

module glbTop import glbPkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    // Configuration
    input  wire                  cfgVld,
    input  wire bankMap_t        cfgBankMap,
    // Write stream
    input  wire                  wrVld,
    input  wire word_t           wrDat,
    output logic                 wrRdy,
    output logic                 wrFull,
    // Read streams
    output logic [NumRdPort-1:0] rdVld,
    input  wire [NumRdPort-1:0]  rdRdy,
    output word_t                rdDat [NumRdPort],
    output logic [NumRdPort-1:0] rdDone
);

    bankMap_t   bankOwner;
    count_t     portBankCount [NumRdPort];
    bankIdx_t   rankBank [NumRdPort][NumBank];
    count_t     wrCount;
    bankWrReq_t wrReq;
    bankRdReq_t bankRdReq [NumBank];
    word_t      bankRdData [NumBank];

    // ==================================================================
    // Configuration and write side
    // ==================================================================
    glbBankMapDecoder glbBankMapDecoder_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfgVld        (cfgVld),
        .cfgBankMap    (cfgBankMap),
        .bankOwner     (bankOwner),
        .portBankCount (portBankCount),
        .rankBank      (rankBank)
    );

    glbWritePort glbWritePort_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfgVld  (cfgVld),
        .wrVld   (wrVld),
        .wrDat   (wrDat),
        .wrRdy   (wrRdy),
        .wrFull  (wrFull),
        .wrCount (wrCount),
        .wrReq   (wrReq)
    );

    // ==================================================================
    // Bank array
    // ==================================================================
    for (genvar b = 0; b < NumBank; b++) begin : genBank
        glbBank glbBank_inst (
            .clk    (clk),
            .rst_n  (rst_n),
            .bankId (bankIdx_t'(b)),
            .wrReq  (wrReq),
            .rdReq  (bankRdReq[b]),
            .rdData (bankRdData[b])
        );
    end

    // ==================================================================
    // Read side
    // ==================================================================
    glbReadPorts glbReadPorts_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfgVld        (cfgVld),
        .bankOwner     (bankOwner),
        .portBankCount (portBankCount),
        .rankBank      (rankBank),
        .wrCount       (wrCount),
        .rdRdy         (rdRdy),
        .bankRdData    (bankRdData),
        .bankRdReq     (bankRdReq),
        .rdVld         (rdVld),
        .rdDat         (rdDat),
        .rdDone        (rdDone)
    );

endmodule

`default_nettype wire

/* glbWritePort.sv */
// Write port of the global buffer
// Fills the banks in linear order from a single stream and broadcasts
// the bank write request; the count restarts on every configuration
`timescale 1ns/1ps
`default_nettype none

module glbWritePort import glbPkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        cfgVld,
    input  wire        wrVld,
    input  wire word_t wrDat,
    output logic       wrRdy,
    output logic       wrFull,
    output count_t     wrCount,
    output bankWrReq_t wrReq
);

    logic  wrAcc;
    addr_t wrAddr;

    // ==================================================================
    // Flow control
    // ==================================================================
    assign wrFull = (wrCount == count_t'(TotalWords));
    assign wrRdy  = ~wrFull;
    assign wrAcc  = wrVld & wrRdy;

    // Count below full always fits the address width
    assign wrAddr = wrCount[AddrWidth-1:0];

    // ==================================================================
    // Broadcast request
    // ==================================================================

    // Upper address bits pick the bank, lower bits the row
    always_comb begin
        wrReq.en   = wrAcc;
        wrReq.bank = wrAddr[AddrWidth-1:RowWidth];
        wrReq.row  = wrAddr[RowWidth-1:0];
        wrReq.data = wrDat;
    end

    // ==================================================================
    // Linear write counter
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrCount <= '0;
        end else if (cfgVld) begin
            wrCount <= '0;
        end else if (wrAcc) begin
            wrCount <= wrCount + 1'b1;
        end
    end

    // Counter saturates at a full buffer until the next configuration
    assert property (@(posedge clk) disable iff (!rst_n)
        wrCount <= count_t'(TotalWords));

endmodule

`default_nettype wire
